/* hdl/pipe_cfg.svh */
// Core sizing macros
//   Data path width, register address width, register count
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// Integer data path width
`define XLEN     32

// Register file addressing
`define REG_AW   5    // Bits in an rs/rd field
`define NUM_REGS 32   // x0..x31, x0 hardwired to zero

`endif

/* hdl/pipe_pkg.sv */
// Shared pipeline types
//   Opcode, ALU op and forward select enums
//   Instruction format structs and the instruction union
`include "pipe_cfg.svh"

package pipe_pkg;

  // Major opcodes understood by the decoder
  typedef enum logic [6:0] {
    OPC_OP    = 7'b0110011,   // Register-register ALU
    OPC_OPIMM = 7'b0010011,   // Add-immediate
    OPC_CMP   = 7'b1100011    // Early compare, resolved in ID
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  // One-hot, youngest stage in the top bit
  typedef enum logic [2:0] {
    FWD_NONE = 3'b000,  // Register file
    FWD_WB   = 3'b001,
    FWD_MEM  = 3'b010,
    FWD_EX   = 3'b100
  } fwd_sel_t;

  // ==============================
  // Instruction formats
  // ==============================
  typedef struct packed {
    logic [6:0]         funct7;   // Bit 5 picks sub over add
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]        imm12;    // Sign-extended in ID
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } i_fmt_t;

  // Same 32-bit word, view chosen by opcode
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

endpackage

/* hdl/instr_decoder.sv */
// Instruction decoder
//   IF/ID register for the incoming word
//   Decode into register fields, immediate and control
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module instr_decoder (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,   // One instruction per strobe
  input  pipe_pkg::instr_t   instr,
  output logic               id_valid,      // Known opcode sitting in ID
  output logic [`REG_AW-1:0] id_rs1,
  output logic [`REG_AW-1:0] id_rs2,
  output logic [`REG_AW-1:0] id_rd,
  output logic [`XLEN-1:0]   id_imm,
  output logic               id_use_imm,
  output pipe_pkg::alu_op_t  id_alu_op,
  output logic               id_reg_write,
  output logic               id_is_cmp
);
  import pipe_pkg::*;

  logic    valid_q;
  instr_t  instr_q;
  opcode_t opc;
  logic    known_op;
  logic    cmp_op;

  // ==============================
  // IF/ID register
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      instr_q <= '0;
    end else begin
      valid_q <= instr_valid;
      if (instr_valid) begin
        instr_q <= instr;   // Hold last word across gaps
      end
    end
  end

  assign opc = opcode_t'(instr_q.r.opcode);

  // Opcode and funct decode
  always_comb begin
    known_op   = 1'b0;
    cmp_op     = 1'b0;
    id_use_imm = 1'b0;
    id_alu_op  = ALU_ADD;
    case (opc)
      OPC_OP: begin
        known_op = 1'b1;
        case (instr_q.r.funct3)
          3'b000:  id_alu_op = instr_q.r.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b100:  id_alu_op = ALU_XOR;
          3'b110:  id_alu_op = ALU_OR;
          3'b111:  id_alu_op = ALU_AND;
          default: id_alu_op = ALU_ADD;
        endcase
      end
      OPC_OPIMM: begin
        known_op   = 1'b1;
        id_use_imm = 1'b1;   // Only addi in this core
      end
      OPC_CMP: begin
        known_op = 1'b1;
        cmp_op   = 1'b1;
      end
      default: known_op = 1'b0;   // Unknown opcode becomes a bubble
    endcase
  end

  assign id_valid  = valid_q & known_op;
  assign id_is_cmp = id_valid & cmp_op;
  assign id_rs1    = instr_q.r.rs1;
  assign id_rs2    = id_use_imm ? '0 : instr_q.r.rs2;  // Imm bits are no source
  assign id_rd     = instr_q.r.rd;
  assign id_imm    = {{(`XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};

  // Compares and x0 destinations never write back
  assign id_reg_write = id_valid & ~cmp_op & (instr_q.r.rd != '0);

  // A compare word reaches ID as a compare that writes nothing
  a_cmp_no_write: assert property (@(posedge clk) disable iff (!arst_n)
    (instr_valid && (instr.r.opcode == OPC_CMP)) |=> (id_is_cmp && !id_reg_write))
    else $error("compare word not decoded as a compare without register write");

endmodule

/* hdl/reg_file.sv */
// Integer register file
//   Two combinational read ports, one synchronous write port
//   x0 reads zero and is never written
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module reg_file (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [`REG_AW-1:0] rd_addr_a,
  input  logic [`REG_AW-1:0] rd_addr_b,
  output logic [`XLEN-1:0]   rd_data_a,
  output logic [`XLEN-1:0]   rd_data_b,
  input  logic               wr_en,
  input  logic [`REG_AW-1:0] wr_addr,
  input  logic [`XLEN-1:0]   wr_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // Write at the clock edge, visible to reads in the next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;   // All registers read zero after reset
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // No internal bypass, WB forwarding covers the write cycle
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

/* hdl/forwarding_unit.sv */
// Forwarding unit
//   Hazard detection for both ID source operands
//   Priority EX > MEM > WB > register file, x0 never forwarded
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module forwarding_unit (
  // ==============================
  // ID sources
  // ==============================
  input  logic [`REG_AW-1:0] id_rs1,
  input  logic [`REG_AW-1:0] id_rs2,
  // ==============================
  // In-flight writers
  // ==============================
  input  logic [`REG_AW-1:0] ex_rd,          // In ID/EX
  input  logic               ex_reg_write,
  input  logic [`REG_AW-1:0] mem_rd,         // In EX/MEM
  input  logic               mem_reg_write,
  input  logic [`REG_AW-1:0] wb_rd,          // In MEM/WB, RF write pending
  input  logic               wb_reg_write,
  output pipe_pkg::fwd_sel_t id_forward_a,
  output pipe_pkg::fwd_sel_t id_forward_b
);
  import pipe_pkg::*;

  // Youngest matching writer wins
  function automatic fwd_sel_t pick_src(input logic [`REG_AW-1:0] rs);
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (rs == '0) begin
      sel = FWD_NONE;                          // x0 is always zero
    end else if (ex_reg_write && (ex_rd == rs)) begin
      sel = FWD_EX;                            // ALU result still in EX
    end else if (mem_reg_write && (mem_rd == rs)) begin
      sel = FWD_MEM;
    end else if (wb_reg_write && (wb_rd == rs)) begin
      sel = FWD_WB;                            // Written at the coming edge
    end
    return sel;
  endfunction

  always_comb begin
    id_forward_a = pick_src(id_rs1);
    id_forward_b = pick_src(id_rs2);
  end

endmodule

/* hdl/exec_pipe.sv */
// Execute pipeline
//   ID operand forwarding muxes and early compare
//   ID/EX and EX/MEM registers, ALU, register file
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module exec_pipe (
  input  logic               clk,
  input  logic               arst_n,
  // ==============================
  // ID stage from decoder
  // ==============================
  input  logic               id_valid,
  input  logic [`REG_AW-1:0] id_rs1,
  input  logic [`REG_AW-1:0] id_rs2,
  input  logic [`REG_AW-1:0] id_rd,
  input  logic [`XLEN-1:0]   id_imm,
  input  logic               id_use_imm,
  input  pipe_pkg::alu_op_t  id_alu_op,
  input  logic               id_reg_write,
  input  logic               id_is_cmp,
  input  pipe_pkg::fwd_sel_t id_forward_a,
  input  pipe_pkg::fwd_sel_t id_forward_b,
  // ==============================
  // From writeback stage
  // ==============================
  input  logic [`XLEN-1:0]   wb_data,        // WB forwarding source
  input  logic               rf_wr_en,
  input  logic [`REG_AW-1:0] rf_wr_addr,
  input  logic [`XLEN-1:0]   rf_wr_data,
  // ==============================
  // Stage state out
  // ==============================
  output logic [`REG_AW-1:0] ex_rd,
  output logic               ex_reg_write,
  output logic               mem_valid,
  output logic [`REG_AW-1:0] mem_rd,
  output logic               mem_reg_write,
  output logic [`XLEN-1:0]   mem_data,
  output logic               cmp_valid,      // One-cycle outcome pulse
  output logic               cmp_equal
);
  import pipe_pkg::*;

  logic [`XLEN-1:0] rf_data_a;
  logic [`XLEN-1:0] rf_data_b;
  logic [`XLEN-1:0] id_op_a;
  logic [`XLEN-1:0] id_op_b;
  logic [`XLEN-1:0] id_src_b;
  logic             ex_valid;
  alu_op_t          ex_alu_op;
  logic [`XLEN-1:0] ex_op_a;
  logic [`XLEN-1:0] ex_op_b;
  logic [`XLEN-1:0] ex_result;

  reg_file i_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr_a (id_rs1),
    .rd_addr_b (id_rs2),
    .rd_data_a (rf_data_a),
    .rd_data_b (rf_data_b),
    .wr_en     (rf_wr_en),
    .wr_addr   (rf_wr_addr),
    .wr_data   (rf_wr_data)
  );

  // Operand source by forward select
  function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                               input logic [`XLEN-1:0] rf_val);
    case (sel)
      FWD_EX:  return ex_result;   // Straight off the ALU
      FWD_MEM: return mem_data;
      FWD_WB:  return wb_data;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    id_op_a  = fwd_mux(id_forward_a, rf_data_a);
    id_op_b  = fwd_mux(id_forward_b, rf_data_b);
    id_src_b = id_use_imm ? id_imm : id_op_b;   // addi takes the immediate
  end

  // ==============================
  // ID compare, ID/EX register
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmp_valid    <= 1'b0;
      cmp_equal    <= 1'b0;
      ex_valid     <= 1'b0;
      ex_rd        <= '0;
      ex_reg_write <= 1'b0;
      ex_alu_op    <= ALU_ADD;
      ex_op_a      <= '0;
      ex_op_b      <= '0;
    end else begin
      cmp_valid    <= id_is_cmp;
      cmp_equal    <= (id_op_a == id_op_b);  // Compare on forwarded values
      ex_valid     <= id_valid;
      ex_rd        <= id_rd;
      ex_reg_write <= id_valid & id_reg_write;
      ex_alu_op    <= id_alu_op;
      ex_op_a      <= id_op_a;
      ex_op_b      <= id_src_b;
    end
  end

  // ALU
  always_comb begin
    case (ex_alu_op)
      ALU_SUB: ex_result = ex_op_a - ex_op_b;
      ALU_AND: ex_result = ex_op_a & ex_op_b;
      ALU_OR:  ex_result = ex_op_a | ex_op_b;
      ALU_XOR: ex_result = ex_op_a ^ ex_op_b;
      default: ex_result = ex_op_a + ex_op_b;
    endcase
  end

  // ==============================
  // EX/MEM register
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_valid     <= 1'b0;
      mem_rd        <= '0;
      mem_reg_write <= 1'b0;
      mem_data      <= '0;
    end else begin
      mem_valid     <= ex_valid;
      mem_rd        <= ex_rd;
      mem_reg_write <= ex_reg_write;
      mem_data      <= ex_result;   // MEM has no memory, pure delay
    end
  end

endmodule

/* hdl/writeback_stage.sv */
// Writeback stage
//   MEM/WB register feeding the register file write
//   and the writeback output port
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module writeback_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               mem_valid,
  input  logic [`REG_AW-1:0] mem_rd,
  input  logic               mem_reg_write,
  input  logic [`XLEN-1:0]   mem_data,
  output logic               wb_valid,
  output logic [`REG_AW-1:0] wb_rd,
  output logic [`XLEN-1:0]   wb_data,
  output logic               wb_reg_write
);

  // MEM/WB register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
    end else begin
      wb_valid <= mem_valid & mem_reg_write;  // Only real writers leave
      wb_rd    <= mem_rd;
      wb_data  <= mem_data;
    end
  end

  // Register file write and port share one set of flops
  assign wb_reg_write = wb_valid;

  // Decoder drops x0 writes three stages upstream
  a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> (wb_rd != '0))
    else $error("writeback to x0");

endmodule

/* hdl/pipe_core_top.sv */
// Pipeline core top level
//   Decoder, forwarding unit, execute pipe, writeback stage
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module pipe_core_top (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  pipe_pkg::instr_t   instr,
  output logic               wb_valid,     // Writeback port
  output logic [`REG_AW-1:0] wb_rd,
  output logic [`XLEN-1:0]   wb_data,
  output logic               cmp_valid,    // Compare outcome
  output logic               cmp_equal
);
  import pipe_pkg::*;

  // ==============================
  // ID stage
  // ==============================
  logic               id_valid;
  logic [`REG_AW-1:0] id_rs1;
  logic [`REG_AW-1:0] id_rs2;
  logic [`REG_AW-1:0] id_rd;
  logic [`XLEN-1:0]   id_imm;
  logic               id_use_imm;
  alu_op_t            id_alu_op;
  logic               id_reg_write;
  logic               id_is_cmp;
  fwd_sel_t           id_forward_a;
  fwd_sel_t           id_forward_b;
  // Later stages
  logic [`REG_AW-1:0] ex_rd;
  logic               ex_reg_write;
  logic               mem_valid;
  logic [`REG_AW-1:0] mem_rd;
  logic               mem_reg_write;
  logic [`XLEN-1:0]   mem_data;
  logic               wb_reg_write;

  instr_decoder i_instr_decoder (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .id_valid     (id_valid),
    .id_rs1       (id_rs1),
    .id_rs2       (id_rs2),
    .id_rd        (id_rd),
    .id_imm       (id_imm),
    .id_use_imm   (id_use_imm),
    .id_alu_op    (id_alu_op),
    .id_reg_write (id_reg_write),
    .id_is_cmp    (id_is_cmp)
  );

  forwarding_unit i_forwarding_unit (
    .id_rs1        (id_rs1),
    .id_rs2        (id_rs2),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .wb_rd         (wb_rd),
    .wb_reg_write  (wb_reg_write),
    .id_forward_a  (id_forward_a),
    .id_forward_b  (id_forward_b)
  );

  exec_pipe i_exec_pipe (
    .clk           (clk),
    .arst_n        (arst_n),
    .id_valid      (id_valid),
    .id_rs1        (id_rs1),
    .id_rs2        (id_rs2),
    .id_rd         (id_rd),
    .id_imm        (id_imm),
    .id_use_imm    (id_use_imm),
    .id_alu_op     (id_alu_op),
    .id_reg_write  (id_reg_write),
    .id_is_cmp     (id_is_cmp),
    .id_forward_a  (id_forward_a),
    .id_forward_b  (id_forward_b),
    .wb_data       (wb_data),
    .rf_wr_en      (wb_reg_write),   // RF written from MEM/WB
    .rf_wr_addr    (wb_rd),
    .rf_wr_data    (wb_data),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .mem_valid     (mem_valid),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .mem_data      (mem_data),
    .cmp_valid     (cmp_valid),
    .cmp_equal     (cmp_equal)
  );

  writeback_stage i_writeback_stage (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_valid     (mem_valid),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .mem_data      (mem_data),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_reg_write  (wb_reg_write)
  );

endmodule

/* test/tb_pipe_core.sv */
// Testbench for the five-stage core
//   Clock, reset, watchdog, register model and output monitor
//   Directed tests for forwarding, early compare and x0, plus a random stream
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module tb_pipe_core;
  import pipe_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int SEED            = 81463;
  localparam int DIRECTED_INSTRS = 60;   // Upper bound over tests 2..5
  localparam int DIRECTED_GAP    = 4;    // Longest idle after a directed instruction
  localparam int RAND_INSTRS     = 200;
  localparam int RAND_MAX_GAP    = 3;
  localparam int DRAIN_CYCLES    = 10;
  localparam int NUM_TESTS       = 6;
  // Reset, all issue slots, and one drain per test
  localparam int WD_CYCLES = 20 + DIRECTED_INSTRS * (1 + DIRECTED_GAP)
                           + RAND_INSTRS * (1 + RAND_MAX_GAP)
                           + NUM_TESTS * (DRAIN_CYCLES + 2);

  logic               clk;
  logic               arst_n;
  logic               instr_valid;
  instr_t             instr;
  logic               wb_valid;
  logic [`REG_AW-1:0] wb_rd;
  logic [`XLEN-1:0]   wb_data;
  logic               cmp_valid;
  logic               cmp_equal;

  int    cyc = 0;        // Rising edges seen so far
  string test_name = "init";

  // ==============================
  // Reference model state
  // ==============================
  logic [`XLEN-1:0]   model_regs [`NUM_REGS];
  logic [`REG_AW-1:0] exp_wb_rd   [$];   // Writebacks in issue order
  logic [`XLEN-1:0]   exp_wb_data [$];
  int                 exp_wb_cyc  [$];
  logic               exp_cmp_eq  [$];   // Compare outcomes in issue order
  int                 exp_cmp_cyc [$];

  pipe_core_top i_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .cmp_valid   (cmp_valid),
    .cmp_equal   (cmp_equal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    report_fail("Watchdog expired, the run took longer than its tests allow");
  end

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_wb(input logic [`REG_AW-1:0] exp_rd, input logic [`XLEN-1:0] exp_data);
    if (wb_rd !== exp_rd || wb_data !== exp_data) begin
      report_fail($sformatf("[ERROR] %s: writeback expected x%0d=%h actual x%0d=%h",
                            test_name, exp_rd, exp_data, wb_rd, wb_data));
    end
  endtask

  task automatic check_cmp(input logic exp_eq);
    if (cmp_equal !== exp_eq) begin
      report_fail($sformatf("[ERROR] %s: cmp_equal expected %0b actual %0b",
                            test_name, exp_eq, cmp_equal));
    end
  endtask

  task automatic check_cycle(input string what, input int exp_cyc, input int act_cyc);
    if (exp_cyc != act_cyc) begin
      report_fail($sformatf("[ERROR] %s: %s cycle expected %0d actual %0d",
                            test_name, what, exp_cyc, act_cyc));
    end
  endtask

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    if (arst_n) begin
      if (wb_valid) begin
        if (exp_wb_rd.size() == 0) begin
          report_fail($sformatf("%s: writeback to x%0d that no instruction produced",
                                test_name, wb_rd));
        end else begin
          check_cycle("writeback", exp_wb_cyc[0], cyc);
          check_wb(exp_wb_rd[0], exp_wb_data[0]);
          void'(exp_wb_rd.pop_front());
          void'(exp_wb_data.pop_front());
          void'(exp_wb_cyc.pop_front());
        end
      end
      if (cmp_valid) begin
        if (exp_cmp_eq.size() == 0) begin
          report_fail($sformatf("%s: compare pulse with no compare issued", test_name));
        end else begin
          check_cycle("compare", exp_cmp_cyc[0], cyc);
          check_cmp(exp_cmp_eq[0]);
          void'(exp_cmp_eq.pop_front());
          void'(exp_cmp_cyc.pop_front());
        end
      end
    end
  end

  // ==============================
  // Model and issue helpers
  // ==============================
  function automatic logic [`XLEN-1:0] reg_val(input logic [`REG_AW-1:0] r);
    return (r == '0) ? '0 : model_regs[r];
  endfunction

  function automatic logic [`XLEN-1:0] alu_ref(input alu_op_t op, input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    case (op)
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      default: return a + b;
    endcase
  endfunction

  // Sampled at the next edge, leaves WB three edges later
  task automatic expect_write(input logic [`REG_AW-1:0] rd, input logic [`XLEN-1:0] val);
    if (rd != '0) begin
      exp_wb_rd.push_back(rd);
      exp_wb_data.push_back(val);
      exp_wb_cyc.push_back(cyc + 4);
      model_regs[rd] = val;
    end
  endtask

  task automatic send(input instr_t w);
    instr_valid = 1'b1;
    instr       = w;
    @(negedge clk);
    instr_valid = 1'b0;   // Next call may raise it again at once
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic issue_op(input alu_op_t op, input logic [`REG_AW-1:0] rd,
                          input logic [`REG_AW-1:0] rs1, input logic [`REG_AW-1:0] rs2);
    instr_t w;
    w = '0;
    w.r.opcode = OPC_OP;
    w.r.rd     = rd;
    w.r.rs1    = rs1;
    w.r.rs2    = rs2;
    case (op)
      ALU_SUB: w.r.funct7 = 7'b0100000;   // funct3 stays 000
      ALU_AND: w.r.funct3 = 3'b111;
      ALU_OR:  w.r.funct3 = 3'b110;
      ALU_XOR: w.r.funct3 = 3'b100;
      default: w.r.funct3 = 3'b000;
    endcase
    expect_write(rd, alu_ref(op, reg_val(rs1), reg_val(rs2)));
    send(w);
  endtask

  task automatic issue_addi(input logic [`REG_AW-1:0] rd, input logic [`REG_AW-1:0] rs1,
                            input logic [11:0] imm);
    instr_t w;
    w = '0;
    w.i.opcode = OPC_OPIMM;
    w.i.rd     = rd;
    w.i.rs1    = rs1;
    w.i.imm12  = imm;
    expect_write(rd, reg_val(rs1) + {{(`XLEN-12){imm[11]}}, imm});
    send(w);
  endtask

  // Outcome pulse one edge after the instruction sits in ID
  task automatic issue_cmp(input logic [`REG_AW-1:0] rs1, input logic [`REG_AW-1:0] rs2);
    instr_t w;
    w = '0;
    w.r.opcode = OPC_CMP;
    w.r.rs1    = rs1;
    w.r.rs2    = rs2;
    exp_cmp_eq.push_back(reg_val(rs1) == reg_val(rs2));
    exp_cmp_cyc.push_back(cyc + 2);
    send(w);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_wb_rd.size() != 0 || exp_cmp_eq.size() != 0) && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (exp_wb_rd.size() != 0 || exp_cmp_eq.size() != 0) begin
      report_fail($sformatf("%s: %0d writebacks and %0d compares never came out",
                            test_name, exp_wb_rd.size(), exp_cmp_eq.size()));
    end
    idle(2);   // Catch stray pulses
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset_idle();
    test_name = "reset_idle";
    repeat (8) begin
      @(negedge clk);
      if (wb_valid !== 1'b0 || cmp_valid !== 1'b0) begin
        report_fail("reset_idle: an output pulse appeared with nothing issued");
      end
    end
  endtask

  task automatic test_independent();
    test_name = "independent";
    issue_addi(5'd1, 5'd0, 12'd100);
    idle(4);
    issue_addi(5'd2, 5'd0, 12'hff9);   // -7
    idle(4);
    issue_addi(5'd3, 5'd0, 12'h5a5);
    idle(4);
    issue_op(ALU_ADD, 5'd5, 5'd1, 5'd2);
    idle(3);
    issue_op(ALU_SUB, 5'd6, 5'd1, 5'd2);
    idle(3);
    issue_op(ALU_AND, 5'd7, 5'd3, 5'd2);
    idle(2);
    issue_op(ALU_OR, 5'd8, 5'd3, 5'd1);
    idle(4);
    issue_op(ALU_XOR, 5'd9, 5'd3, 5'd2);
    drain();
  endtask

  task automatic test_forward_chains();
    test_name = "forward_chains";
    for (int d = 1; d <= 3; d++) begin   // 1 hits EX, 2 MEM, 3 WB
      issue_addi(5'd10, 5'd0, 12'(11 * d));
      idle(d - 1);
      issue_op(ALU_ADD, 5'd11, 5'd10, 5'd10);
      idle(d - 1);
      issue_op(ALU_SUB, 5'd12, 5'd11, 5'd10);
      idle(d - 1);
      issue_op(ALU_XOR, 5'd13, 5'd12, 5'd11);
      idle(4);
    end
    // Mixed distances on the two sources
    issue_addi(5'd14, 5'd0, 12'd3);
    issue_addi(5'd15, 5'd0, 12'd5);
    issue_addi(5'd16, 5'd0, 12'd7);
    issue_op(ALU_ADD, 5'd17, 5'd14, 5'd16);
    // Youngest writer of the same register must win
    issue_addi(5'd20, 5'd0, 12'd1);
    issue_addi(5'd20, 5'd0, 12'd2);
    issue_op(ALU_OR, 5'd21, 5'd20, 5'd20);
    drain();
  endtask

  task automatic test_early_compare();
    test_name = "early_compare";
    issue_addi(5'd24, 5'd0, 12'd10);
    idle(4);
    for (int d = 1; d <= 3; d++) begin
      issue_addi(5'd22, 5'd0, 12'd10);
      idle(d - 1);
      issue_cmp(5'd22, 5'd24);   // Equal
      issue_addi(5'd22, 5'd0, 12'd11);
      idle(d - 1);
      issue_cmp(5'd24, 5'd22);   // Not equal
      idle(4);
    end
    issue_addi(5'd25, 5'd0, 12'd7);
    issue_addi(5'd26, 5'd0, 12'd7);
    issue_cmp(5'd25, 5'd26);     // Both sources forwarded
    drain();
  endtask

  task automatic test_x0_dest();
    test_name = "x0_dest";
    issue_addi(5'd0, 5'd0, 12'd55);   // No writeback expected
    issue_op(ALU_ADD, 5'd0, 5'd24, 5'd25);
    issue_op(ALU_ADD, 5'd27, 5'd0, 5'd0);
    issue_cmp(5'd0, 5'd0);
    issue_addi(5'd29, 5'd0, 12'd1);
    issue_cmp(5'd29, 5'd0);
    drain();
  endtask

  task automatic test_random_stream();
    int                 kind;
    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    test_name = "random_stream";
    for (int i = 0; i < RAND_INSTRS; i++) begin
      kind = $urandom % 3;
      rd   = `REG_AW'($urandom);
      rs1  = `REG_AW'($urandom);
      rs2  = `REG_AW'($urandom);
      case (kind)
        0:       issue_op(alu_op_t'($urandom % 5), rd, rs1, rs2);
        1:       issue_addi(rd, rs1, 12'($urandom));
        default: issue_cmp(rs1, rs2);
      endcase
      idle($urandom % (RAND_MAX_GAP + 1));
    end
    drain();
  endtask

  initial begin
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      model_regs[r] = '0;   // Matches the register file after reset
    end
    void'($urandom(SEED));
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    test_reset_idle();
    test_independent();
    test_forward_chains();
    test_early_compare();
    test_x0_dest();
    test_random_stream();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/pipe_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/forwarding_unit.sv
hdl/exec_pipe.sv
hdl/writeback_stage.sv
hdl/pipe_core_top.sv
test/tb_pipe_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_pipe_core \
  -o sim_tb > sim.log 2>&1 \
  && ./obj_dir/sim_tb >> sim.log 2>&1 \
  || echo "Build or run ended with an error status" >> sim.log

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Build or run ended with an error status" sim.log && exit 1
exit 0
